// File: adc5g_regmap_pkg.sv
/*
 * ADC5G register map
 * word offsets, config word fields and chip reset length of the Wishbone window
 */
package adc5g_regmap_pkg;

  // word offset sits in wb_adr_i[4:2]
  localparam int ADDR_LSB = 2;
  localparam int ADDR_W   = 3;

  localparam logic [ADDR_W-1:0] REG_RESET = 3'd0; // per-chip reset pulse
  localparam logic [ADDR_W-1:0] REG_CFG0  = 3'd1; // adc 0 serial command
  localparam logic [ADDR_W-1:0] REG_CFG1  = 3'd2; // adc 1 serial command

  localparam int CFG_START_BIT = 0; // write side
  localparam int CFG_DONE_BIT  = 0; // read side
  localparam int CFG_ADDR_LSB  = 8;
  localparam int CFG_DATA_LSB  = 16;

  localparam logic [7:0] RST_LENGTH = 8'd16; // clocks

  localparam int NUM_ADC = 2;

endpackage

// File: adc3wire_pkg.sv
/*
 * ADC three-wire serial port definitions
 * command, status and pin bundles plus serial clock strobe positions
 */
package adc3wire_pkg;

  localparam int ADDR_BITS = 8;
  localparam int DATA_BITS = 16;

  // one serial period is 2**SCLK_DIV_W clocks
  localparam int SCLK_DIV_W = 5;

  localparam logic [SCLK_DIV_W-1:0] CNT_FALL    = 5'd0;  // sdata update
  localparam logic [SCLK_DIV_W-1:0] CNT_PRERISE = 5'd15; // read sample point
  localparam logic [SCLK_DIV_W-1:0] CNT_MIDHIGH = 5'd24; // end of frame check

  // addr[7] set selects a write frame
  typedef struct packed {
    logic [ADDR_BITS-1:0] addr;
    logic [DATA_BITS-1:0] data;
  } adc3wire_cmd_t;

  typedef struct packed {
    logic                 done;
    logic [DATA_BITS-1:0] rdata; // last read frame
  } adc3wire_stat_t;

  typedef struct packed {
    logic sclk;
    logic sdata;
    logic mode_n; // low while a frame is on the wires
  } adc3wire_pins_t;

endpackage

// File: adc5g_wb_regs.sv
/*
 * ADC5G Wishbone register slave
 * decodes the register window, holds the serial commands and builds read data
 */
`timescale 1ns/1ps

module adc5g_wb_regs
  import adc5g_regmap_pkg::*, adc3wire_pkg::*;
(
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [31:0]          wb_adr_i,
  input  logic [3:0]           wb_sel_i,
  input  logic [31:0]          wb_dat_i,
  output logic                 wb_ack_o,
  output logic [31:0]          wb_dat_o,
  output logic [NUM_ADC-1:0]   cfg_start_o,
  output adc3wire_cmd_t        cfg_cmd_o [NUM_ADC],
  input  adc3wire_stat_t       cfg_stat_i [NUM_ADC],
  output logic [NUM_ADC-1:0]   rst_req_o,
  input  logic [NUM_ADC-1:0]   adc_reset_i
);

  logic [ADDR_W-1:0]  word;
  logic [NUM_ADC-1:0] cfg_hit;
  logic [NUM_ADC-1:0] done_vec;
  logic               accept;
  logic [31:0]        rd_data;
  logic [31:0]        dat_q;

  assign word       = wb_adr_i[ADDR_LSB +: ADDR_W];
  assign cfg_hit[0] = (word == REG_CFG0);
  assign cfg_hit[1] = (word == REG_CFG1);

  always_comb begin
    for (int i = 0; i < NUM_ADC; i++) begin
      done_vec[i] = cfg_stat_i[i].done;
    end
  end

  // a busy engine stalls its own word only
  assign accept = wb_cyc_i && wb_stb_i && !wb_ack_o && !(|(cfg_hit & ~done_vec));

  always_comb begin
    rd_data = '0;
    if (word == REG_RESET) begin
      rd_data[NUM_ADC-1:0] = adc_reset_i; // live levels
    end
    for (int i = 0; i < NUM_ADC; i++) begin
      if (cfg_hit[i]) begin
        rd_data[CFG_DATA_LSB +: DATA_BITS] = cfg_stat_i[i].rdata;
        rd_data[CFG_ADDR_LSB +: ADDR_BITS] = cfg_cmd_o[i].addr;
        rd_data[CFG_DONE_BIT]              = cfg_stat_i[i].done;
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o    <= 1'b0;
      cfg_start_o <= '0;
      rst_req_o   <= '0;
      for (int i = 0; i < NUM_ADC; i++) begin
        cfg_cmd_o[i] <= '0;
      end
    end else begin
      wb_ack_o    <= accept;
      cfg_start_o <= '0; // single cycle pulses
      rst_req_o   <= '0;
      if (accept && wb_we_i) begin
        if (word == REG_RESET && wb_sel_i[0]) begin
          rst_req_o <= wb_dat_i[NUM_ADC-1:0];
        end
        for (int i = 0; i < NUM_ADC; i++) begin
          if (cfg_hit[i]) begin
            if (wb_sel_i[0]) begin
              cfg_start_o[i] <= wb_dat_i[CFG_START_BIT];
            end
            if (wb_sel_i[1]) begin
              cfg_cmd_o[i].addr <= wb_dat_i[CFG_ADDR_LSB +: ADDR_BITS];
            end
            if (wb_sel_i[2]) begin
              cfg_cmd_o[i].data[7:0] <= wb_dat_i[CFG_DATA_LSB +: 8];
            end
            if (wb_sel_i[3]) begin
              cfg_cmd_o[i].data[15:8] <= wb_dat_i[CFG_DATA_LSB + 8 +: 8];
            end
          end
        end
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (accept) begin
      dat_q <= wb_we_i ? '0 : rd_data;
    end
  end

  assign wb_dat_o = wb_ack_o ? dat_q : '0;

endmodule

// File: adc3wire_master.sv
/*
 * ADC three-wire serial engine
 * divides wb_clk_i into sclk, shifts out address and data, samples read data
 */
`timescale 1ns/1ps

module adc3wire_master
  import adc3wire_pkg::*;
(
  input  logic           wb_clk_i,
  input  logic           wb_rst_i,
  input  logic           start_i,
  input  adc3wire_cmd_t  cmd_i,
  input  logic           sdata_i,
  output adc3wire_stat_t stat_o,
  output adc3wire_pins_t pins_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CLKWAIT,
    ST_ADDR,
    ST_WDATA,
    ST_RTURN,
    ST_RDATA,
    ST_ALMOST,
    ST_FINISH
  } state_e;

  state_e                                     state_q;
  logic [SCLK_DIV_W-1:0]                      div_q;
  logic                                       fall_stb;
  logic                                       prerise_stb;
  logic                                       midhigh_stb;
  logic [$clog2(ADDR_BITS + DATA_BITS + 1)-1:0] bit_cnt_q;
  logic                                       wr_q;
  logic [ADDR_BITS+DATA_BITS-1:0]             tx_q;
  logic [DATA_BITS-1:0]                       rx_q;
  logic [DATA_BITS-1:0]                       rdata_q;
  logic                                       frame_act;

  assign fall_stb    = (div_q == CNT_FALL);
  assign prerise_stb = (div_q == CNT_PRERISE);
  assign midhigh_stb = (div_q == CNT_MIDHIGH);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || state_q == ST_IDLE) begin
      div_q <= '0; // restart each frame
    end else begin
      div_q <= div_q + 1'b1;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state_q   <= ST_IDLE;
      bit_cnt_q <= '0;
      wr_q      <= 1'b0;
      rdata_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            state_q <= ST_CLKWAIT;
            wr_q    <= cmd_i.addr[ADDR_BITS-1];
          end
        end
        ST_CLKWAIT: begin
          if (fall_stb) begin
            state_q   <= ST_ADDR;
            bit_cnt_q <= '0;
          end
        end
        ST_ADDR: begin
          if (fall_stb) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == ADDR_BITS - 1) begin
              state_q <= wr_q ? ST_WDATA : ST_RTURN;
            end
          end
        end
        ST_WDATA: begin
          if (fall_stb) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
          end
          if (midhigh_stb && bit_cnt_q == ADDR_BITS + DATA_BITS - 1) begin
            state_q <= ST_ALMOST;
          end
        end
        ST_RTURN: begin
          if (fall_stb) begin
            state_q <= ST_RDATA; // one idle period, sclk held low
          end
        end
        ST_RDATA: begin
          if (prerise_stb) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
          end
          if (midhigh_stb && bit_cnt_q == ADDR_BITS + DATA_BITS) begin
            state_q <= ST_ALMOST;
          end
        end
        ST_ALMOST: begin
          if (prerise_stb) begin
            state_q <= ST_FINISH;
          end
        end
        ST_FINISH: begin
          if (fall_stb) begin
            state_q <= ST_IDLE;
            rdata_q <= rx_q; // with done
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (state_q == ST_IDLE && start_i) begin
      tx_q <= cmd_i;
      rx_q <= '0;
    end else begin
      if (fall_stb && (state_q == ST_ADDR || state_q == ST_WDATA)) begin
        tx_q <= tx_q << 1; // msb first
      end
      if (prerise_stb && state_q == ST_RDATA) begin
        rx_q <= {rx_q[DATA_BITS-2:0], sdata_i};
      end
    end
  end

  assign frame_act = (state_q inside {ST_ADDR, ST_WDATA, ST_RTURN, ST_RDATA, ST_ALMOST});

  assign pins_o.sclk   = div_q[SCLK_DIV_W-1] && frame_act && (state_q != ST_RTURN);
  assign pins_o.sdata  = frame_act && tx_q[ADDR_BITS+DATA_BITS-1];
  assign pins_o.mode_n = !frame_act;

  assign stat_o.done  = (state_q == ST_IDLE);
  assign stat_o.rdata = rdata_q;

endmodule

// File: adc_reset_stretch.sv
/*
 * ADC reset stretcher
 * holds the chip reset for RST_LENGTH clocks after a request or bus reset
 */
`timescale 1ns/1ps

module adc_reset_stretch
  import adc5g_regmap_pkg::*;
(
  input  logic wb_clk_i,
  input  logic wb_rst_i,
  input  logic req_i,
  output logic adc_reset_o
);

  logic [7:0] cnt_q;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || req_i) begin
      cnt_q <= RST_LENGTH; // reload
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign adc_reset_o = (cnt_q != '0);

endmodule

// File: adc5g_ctrl_top.sv
/*
 * ADC5G configuration controller
 * Wishbone registers feeding one serial engine and reset stretcher per chip
 */
`timescale 1ns/1ps

module adc5g_ctrl_top
  import adc5g_regmap_pkg::*, adc3wire_pkg::*;
(
  input  logic           wb_clk_i,
  input  logic           wb_rst_i,
  input  logic           wb_cyc_i,
  input  logic           wb_stb_i,
  input  logic           wb_we_i,
  input  logic [31:0]    wb_adr_i,
  input  logic [3:0]     wb_sel_i,
  input  logic [31:0]    wb_dat_i,
  output logic [31:0]    wb_dat_o,
  output logic           wb_ack_o,
  output adc3wire_pins_t adc0_pins_o,
  output adc3wire_pins_t adc1_pins_o,
  input  logic           adc0_sdata_i,
  input  logic           adc1_sdata_i,
  output logic           adc0_reset_o,
  output logic           adc1_reset_o
);

  logic [NUM_ADC-1:0] cfg_start;
  adc3wire_cmd_t      cfg_cmd  [NUM_ADC];
  adc3wire_stat_t     cfg_stat [NUM_ADC];
  logic [NUM_ADC-1:0] rst_req;
  logic [NUM_ADC-1:0] adc_reset;
  logic [NUM_ADC-1:0] sdata;
  adc3wire_pins_t     pins [NUM_ADC];

  adc5g_wb_regs u_regs (
    .wb_clk_i, .wb_rst_i, .wb_cyc_i, .wb_stb_i, .wb_we_i,
    .wb_adr_i, .wb_sel_i, .wb_dat_i, .wb_ack_o, .wb_dat_o,
    .cfg_start_o (cfg_start),
    .cfg_cmd_o   (cfg_cmd),
    .cfg_stat_i  (cfg_stat),
    .rst_req_o   (rst_req),
    .adc_reset_i (adc_reset)
  );

  assign sdata = {adc1_sdata_i, adc0_sdata_i};

  for (genvar i = 0; i < NUM_ADC; i++) begin : g_adc
    adc3wire_master u_spi (
      .wb_clk_i, .wb_rst_i,
      .start_i (cfg_start[i]),
      .cmd_i   (cfg_cmd[i]),
      .sdata_i (sdata[i]),
      .stat_o  (cfg_stat[i]),
      .pins_o  (pins[i])
    );

    adc_reset_stretch u_rst (
      .wb_clk_i, .wb_rst_i,
      .req_i       (rst_req[i]),
      .adc_reset_o (adc_reset[i])
    );
  end

  assign adc0_pins_o  = pins[0];
  assign adc1_pins_o  = pins[1];
  assign adc0_reset_o = adc_reset[0];
  assign adc1_reset_o = adc_reset[1];

endmodule

// File: tb_clk_gen.sv
/*
 * Testbench clock and reset source
 * 20 ns wb_clk_i, reset held for three cycles
 */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic wb_clk_o,
  output logic wb_rst_o
);

  initial begin
    wb_clk_o = 1'b0;
    forever #10 wb_clk_o = ~wb_clk_o;
  end

  initial begin
    wb_rst_o = 1'b1;
    repeat (3) @(posedge wb_clk_o);
    @(negedge wb_clk_o); // released away from the active edge
    wb_rst_o = 1'b0;
  end

endmodule

// File: adc5g_checker.sv
/*
 * ADC5G controller monitor
 * keeps a reference model of the registers, frames and reset windows
 */
`timescale 1ns/1ps

module adc5g_checker
  import adc5g_regmap_pkg::*, adc3wire_pkg::*;
(
  input  logic           wb_clk_i,
  input  logic           wb_rst_i,
  input  logic           wb_cyc_i,
  input  logic           wb_stb_i,
  input  logic           wb_we_i,
  input  logic [31:0]    wb_adr_i,
  input  logic [3:0]     wb_sel_i,
  input  logic [31:0]    wb_dat_i,
  input  logic [31:0]    wb_dat_o,
  input  logic           wb_ack_o,
  input  adc3wire_pins_t pins_i [NUM_ADC],
  input  logic [1:0]     adc_reset_i,
  input  logic [15:0]    slave_word_i [NUM_ADC],
  output int             checks_o,
  output int             value_errs_o,
  output int             proto_errs_o
);

  adc3wire_cmd_t  held      [NUM_ADC];
  adc3wire_cmd_t  frame_cmd [NUM_ADC];
  logic [15:0]    rdata_m   [NUM_ADC];
  logic           pending   [NUM_ADC];
  int             rst_cnt   [NUM_ADC];
  int             rises     [NUM_ADC];
  logic [23:0]    shreg     [NUM_ADC];
  logic           sclk_prev [NUM_ADC];
  logic           mode_prev [NUM_ADC];
  logic [1:0]     lvl_prev;
  logic           started;

  initial begin
    checks_o     = 0;
    value_errs_o = 0;
    proto_errs_o = 0;
    started      = 1'b0;
    lvl_prev     = '0;
    for (int i = 0; i < NUM_ADC; i++) begin
      held[i]      = '0;
      rdata_m[i]   = '0;
      pending[i]   = 1'b0;
      rst_cnt[i]   = 0;
      rises[i]     = 0;
      sclk_prev[i] = 1'b0;
      mode_prev[i] = 1'b1;
    end
  end

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    checks_o++;
    if (act !== exp) begin
      value_errs_o++;
      $display("Error at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
    end
  endtask

  task automatic protocol_error(input string what);
    proto_errs_o++;
    $display("At %0t ns: %s", $time, what);
  endtask

  // bus side, sampled values of the cycle that just ended
  always @(posedge wb_clk_i) begin : bus_side
    logic [ADDR_W-1:0] word;
    logic [31:0]       exp;
    logic [1:0]        lvl;
    word = wb_adr_i[ADDR_LSB +: ADDR_W];
    for (int i = 0; i < NUM_ADC; i++) begin
      lvl[i] = (rst_cnt[i] != 0);
      if (started) begin
        compare_value($sformatf("adc%0d_reset_o", i), lvl[i], adc_reset_i[i]);
      end
    end
    if (wb_ack_o) begin
      if (!(wb_cyc_i && wb_stb_i)) begin
        protocol_error("acknowledge without a bus request");
      end
      exp = '0;
      if (!wb_we_i && word == REG_RESET) begin
        exp[1:0] = lvl_prev; // levels at the accept edge
      end
      for (int i = 0; i < NUM_ADC; i++) begin
        if (word == REG_CFG0 + i) begin
          if (pending[i]) begin
            protocol_error($sformatf("access to busy engine %0d was acknowledged", i));
          end
          if (wb_we_i) begin
            if (wb_sel_i[1]) held[i].addr = wb_dat_i[15:8];
            if (wb_sel_i[2]) held[i].data[7:0] = wb_dat_i[23:16];
            if (wb_sel_i[3]) held[i].data[15:8] = wb_dat_i[31:24];
            if (wb_sel_i[0] && wb_dat_i[0]) begin
              pending[i]   = 1'b1;
              frame_cmd[i] = held[i];
            end
          end else begin
            exp = {rdata_m[i], held[i].addr, 7'b0, 1'b1};
          end
        end
      end
      compare_value("wb_dat_o", exp, wb_dat_o);
    end
    for (int i = 0; i < NUM_ADC; i++) begin
      if (wb_rst_i || (wb_ack_o && wb_we_i && word == REG_RESET && wb_sel_i[0] &&
                       wb_dat_i[i])) begin
        rst_cnt[i] = 16;
      end else if (rst_cnt[i] != 0) begin
        rst_cnt[i] = rst_cnt[i] - 1;
      end
      if (wb_rst_i) begin
        held[i]    = '0;
        rdata_m[i] = '0;
        pending[i] = 1'b0;
      end
    end
    if (wb_rst_i) started = 1'b1;
    lvl_prev = lvl;
  end

  // serial side, pins sampled mid-cycle
  always @(negedge wb_clk_i) begin : frame_side
    for (int i = 0; i < NUM_ADC; i++) begin
      if (!pins_i[i].mode_n && pins_i[i].sclk && !sclk_prev[i]) begin
        shreg[i] = {shreg[i][22:0], pins_i[i].sdata};
        rises[i]++;
      end
      if (pins_i[i].mode_n && !mode_prev[i]) begin // end of frame
        if (!pending[i]) begin
          protocol_error($sformatf("frame on adc%0d without a start command", i));
        end else begin
          compare_value($sformatf("adc%0d sclk rises", i), 24, rises[i]);
          if (frame_cmd[i].addr[7]) begin
            compare_value($sformatf("adc%0d write frame", i), frame_cmd[i], shreg[i]);
            rdata_m[i] = '0; // nothing sampled
          end else begin
            compare_value($sformatf("adc%0d read address", i), frame_cmd[i].addr,
                          shreg[i][23:16]);
            rdata_m[i] = slave_word_i[i];
          end
        end
        pending[i] = 1'b0;
        rises[i]   = 0;
      end
      sclk_prev[i] = pins_i[i].sclk;
      mode_prev[i] = pins_i[i].mode_n;
    end
  end

endmodule

// File: adc5g_ctrl_properties.sv
/*
 * ADC5G controller assertions
 * bus and serial pin rules, bound to the top level
 */
`timescale 1ns/1ps

module adc5g_ctrl_properties
  import adc3wire_pkg::*;
(
  input logic           wb_clk_i,
  input logic           wb_rst_i,
  input logic           wb_ack_o,
  input logic [31:0]    wb_dat_o,
  input adc3wire_pins_t adc0_pins_o,
  input adc3wire_pins_t adc1_pins_o,
  input logic [1:0]     done_i
);

  int fail_cnt = 0; // failed assertions so far

  a_dat_idle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !wb_ack_o |-> wb_dat_o == '0)
    else begin
      fail_cnt++;
      $error("read data without acknowledge");
    end

  a_ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |=> !wb_ack_o)
    else begin
      fail_cnt++;
      $error("acknowledge held for two cycles");
    end

  a_sclk_idle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (adc0_pins_o.mode_n |-> !adc0_pins_o.sclk) and
    (adc1_pins_o.mode_n |-> !adc1_pins_o.sclk))
    else begin
      fail_cnt++;
      $error("sclk toggles outside a frame");
    end

  a_idle_mode: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (&done_i) |-> (adc0_pins_o.mode_n && adc1_pins_o.mode_n))
    else begin
      fail_cnt++;
      $error("mode_n low with both engines done");
    end

endmodule

bind adc5g_ctrl_top adc5g_ctrl_properties u_props (
  .wb_clk_i, .wb_rst_i, .wb_ack_o, .wb_dat_o, .adc0_pins_o, .adc1_pins_o,
  .done_i ({cfg_stat[1].done, cfg_stat[0].done})
);

// File: tb_adc5g_ctrl.sv
/*
 * ADC5G controller testbench
 * random Wishbone traffic, serial slave models, checker and watchdog
 */
`timescale 1ns/1ps

module tb_adc5g_ctrl
  import adc5g_regmap_pkg::*, adc3wire_pkg::*;
();

  localparam int N_TRANS     = 40;
  localparam int WATCHDOG_NS = N_TRANS * 40 * (2 ** SCLK_DIV_W) * 20; // 40 serial periods each

  logic           wb_clk, wb_rst;
  logic           wb_cyc, wb_stb, wb_we, wb_ack;
  logic [31:0]    wb_adr, wb_dat_w, wb_dat_r;
  logic [3:0]     wb_sel;
  adc3wire_pins_t pins [NUM_ADC];
  logic           sdata [NUM_ADC];
  logic [15:0]    slave_word [NUM_ADC];
  logic [1:0]     adc_reset;
  int             seed = 27345;
  int             checks, value_errs, proto_errs;

  tb_clk_gen u_clk (.wb_clk_o (wb_clk), .wb_rst_o (wb_rst));

  adc5g_ctrl_top uut (
    .wb_clk_i (wb_clk), .wb_rst_i (wb_rst), .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb),
    .wb_we_i (wb_we), .wb_adr_i (wb_adr), .wb_sel_i (wb_sel), .wb_dat_i (wb_dat_w),
    .wb_dat_o (wb_dat_r), .wb_ack_o (wb_ack),
    .adc0_pins_o (pins[0]), .adc1_pins_o (pins[1]),
    .adc0_sdata_i (sdata[0]), .adc1_sdata_i (sdata[1]),
    .adc0_reset_o (adc_reset[0]), .adc1_reset_o (adc_reset[1])
  );

  adc5g_checker u_chk (
    .wb_clk_i (wb_clk), .wb_rst_i (wb_rst), .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb),
    .wb_we_i (wb_we), .wb_adr_i (wb_adr), .wb_sel_i (wb_sel), .wb_dat_i (wb_dat_w),
    .wb_dat_o (wb_dat_r), .wb_ack_o (wb_ack), .pins_i (pins), .adc_reset_i (adc_reset),
    .slave_word_i (slave_word), .checks_o (checks), .value_errs_o (value_errs),
    .proto_errs_o (proto_errs)
  );

  // chip model shifts the read word out msb first after the address
  for (genvar g = 0; g < NUM_ADC; g++) begin : g_slave
    int         rises;
    logic [7:0] addr_sh;
    logic       sclk_prev;
    initial begin
      rises         = 0;
      sclk_prev     = 1'b0;
      sdata[g]      = 1'b0;
      slave_word[g] = '0;
    end
    always @(negedge wb_clk) begin
      if (pins[g].mode_n) begin
        rises    = 0;
        sdata[g] = 1'b0;
      end else if (pins[g].sclk && !sclk_prev) begin
        rises = rises + 1;
        if (rises <= ADDR_BITS) addr_sh = {addr_sh[6:0], pins[g].sdata};
        if (rises == ADDR_BITS && !addr_sh[7]) slave_word[g] = $random(seed);
        if (rises >= ADDR_BITS && rises < ADDR_BITS + DATA_BITS && !addr_sh[7]) begin
          sdata[g] = slave_word[g][ADDR_BITS + DATA_BITS - 1 - rises];
        end else begin
          sdata[g] = 1'b0;
        end
      end
      sclk_prev = pins[g].sclk;
    end
  end

  task automatic bus_access(input logic we, input logic [31:0] adr,
                            input logic [3:0] sel, input logic [31:0] dat);
    @(negedge wb_clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_sel   = sel;
    wb_dat_w = dat;
    do @(negedge wb_clk); while (!wb_ack);
    @(negedge wb_clk); // hold through the ack edge
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  initial begin : stimulus
    int          kind;
    int          chip;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_sel   = '0;
    wb_dat_w = '0;
    wait (!wb_rst);
    repeat (20) @(negedge wb_clk); // let the reset window run out
    for (int n = 0; n < N_TRANS; n++) begin
      kind = $unsigned($random(seed)) % 10;
      chip = $unsigned($random(seed)) % 2;
      adr  = $random(seed);
      dat  = $random(seed);
      sel  = $random(seed);
      case (kind)
        0, 1, 2, 3, 4: begin
          adr[4:2] = REG_CFG0 + chip;
          dat[0]   = 1'b1;
          bus_access(1'b1, adr, sel, dat);
        end
        5, 6: begin
          adr[4:2] = REG_CFG0 + chip;
          bus_access(1'b0, adr, sel, dat);
        end
        7: begin
          adr[4:2] = REG_RESET;
          bus_access(1'b1, adr, sel, dat);
        end
        8: begin
          adr[4:2] = REG_RESET;
          bus_access(1'b0, adr, sel, dat);
        end
        default: begin
          adr[4:2] = 3 + $unsigned($random(seed)) % 5; // unmapped words
          bus_access(1'b0, adr, sel, dat);
        end
      endcase
    end
    bus_access(1'b0, {27'd0, REG_CFG0, 2'b00}, 4'hf, '0);
    bus_access(1'b0, {27'd0, REG_CFG1, 2'b00}, 4'hf, '0);
    bus_access(1'b1, {27'd0, REG_RESET, 2'b00}, 4'h1, 32'h3);
    bus_access(1'b0, {27'd0, REG_RESET, 2'b00}, 4'hf, '0);
    repeat (40) @(negedge wb_clk);
    $display("checks %0d, value errors %0d, protocol errors %0d, assertion failures %0d",
             checks, value_errs, proto_errs, uut.u_props.fail_cnt);
    if (value_errs == 0 && proto_errs == 0 && uut.u_props.fail_cnt == 0 && checks > 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS * 1ns);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: files.f
adc5g_regmap_pkg.sv
adc3wire_pkg.sv
adc5g_wb_regs.sv
adc3wire_master.sv
adc_reset_stretch.sv
adc5g_ctrl_top.sv
tb_clk_gen.sv
adc5g_checker.sv
adc5g_ctrl_properties.sv
tb_adc5g_ctrl.sv
